/* source/lite_mux_consts.svh */
// AXI4-Lite multiplexer constants for port count, channel widths and routing depth
`ifndef LITE_MUX_CONSTS_SVH
`define LITE_MUX_CONSTS_SVH

// Upstream ports and the width of a port index
`define LM_NUM_PORTS 4
`define LM_SEL_W 2

// Channel field widths
`define LM_ADDR_W 32
`define LM_DATA_W 32
`define LM_STRB_W 4
`define LM_PROT_W 3
`define LM_RESP_W 2

// Routing FIFO depth, bounds transactions in flight per direction
`define LM_MAX_TRANS 4

// Response codes
`define LM_RESP_OKAY 2'b00
`define LM_RESP_SLVERR 2'b10

`endif

/* source/lite_mux_pkg.sv */
// AXI4-Lite multiplexer channel, request, response and port-select types
`include "lite_mux_consts.svh"

package lite_mux_pkg;

  // Port index stored in the routing FIFOs
  typedef logic [`LM_SEL_W-1:0] sel_t;

  // ------------------------------------------------------------------------
  // Channel payloads
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [`LM_ADDR_W-1:0] addr;
    logic [`LM_PROT_W-1:0] prot;
  } aw_chan_t;

  typedef struct packed {
    logic [`LM_DATA_W-1:0] data;
    logic [`LM_STRB_W-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    logic [`LM_RESP_W-1:0] resp;
  } b_chan_t;

  typedef struct packed {
    logic [`LM_ADDR_W-1:0] addr;
    logic [`LM_PROT_W-1:0] prot;
  } ar_chan_t;

  typedef struct packed {
    logic [`LM_DATA_W-1:0] data;
    logic [`LM_RESP_W-1:0] resp;
  } r_chan_t;

  // ------------------------------------------------------------------------
  // Bundles, master to slave and back
  // ------------------------------------------------------------------------
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } lite_resp_t;

endpackage

/* source/rr_arbiter.sv */
// Round-robin arbiter with lock-in, picks one port's address channel
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module rr_arbiter #(
  parameter type data_t = logic
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [`LM_NUM_PORTS-1:0]        req_i,
  input  data_t [`LM_NUM_PORTS-1:0]       data_i,
  output logic [`LM_NUM_PORTS-1:0]        gnt_o,
  output logic                            valid_o,
  input  logic                            ready_i,
  output data_t                           data_o,
  output lite_mux_pkg::sel_t              idx_o
);

  // Rotating priority pointer
  lite_mux_pkg::sel_t rr_q;
  // Held grant while the output waits for ready
  logic               lock_q;
  lite_mux_pkg::sel_t lock_idx_q;

  // First requester at or after the pointer
  always_comb begin : pick_idx
    int unsigned cand;
    logic        found;
    found = 1'b0;
    idx_o = rr_q;
    for (int unsigned k = 0; k < `LM_NUM_PORTS; k++) begin
      cand = (int'(rr_q) + k) % `LM_NUM_PORTS;
      if (!found && req_i[cand]) begin
        idx_o = lite_mux_pkg::sel_t'(cand);
        found = 1'b1;
      end
    end
    // Lock-in overrides the search
    if (lock_q) begin
      idx_o = lock_idx_q;
    end
  end

  assign valid_o = req_i[idx_o];
  assign data_o  = data_i[idx_o];

  // Ready goes only to the selected port
  for (genvar i = 0; i < `LM_NUM_PORTS; i++) begin : gen_gnt
    assign gnt_o[i] = valid_o & ready_i & (idx_o == lite_mux_pkg::sel_t'(i));
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (valid_o && ready_i) begin
      // Transfer done, move one past the winner
      lock_q <= 1'b0;
      if (int'(idx_o) == `LM_NUM_PORTS - 1) begin
        rr_q <= '0;
      end else begin
        rr_q <= idx_o + 1'b1;
      end
    end else if (valid_o) begin
      // Stalled, keep this port granted
      lock_q     <= 1'b1;
      lock_idx_q <= idx_o;
    end
  end

endmodule

/* source/route_fifo.sv */
// Small FIFO of port indices that records the routing order of transactions
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module route_fifo #(
  parameter int unsigned depth = `LM_MAX_TRANS
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               push_i,
  input  logic               pop_i,
  input  lite_mux_pkg::sel_t data_i,
  output lite_mux_pkg::sel_t data_o,
  output logic               full_o,
  output logic               empty_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  // Storage, no reset needed
  lite_mux_pkg::sel_t mem_q [depth];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (cnt_q == cnt_w'(depth));
  assign empty_o = (cnt_q == '0);
  // Overflow and underflow are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  // Head entry
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at depth, not at a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

/* source/write_mux.sv */
// Write path: arbitrates AW, steers W in address order and returns B to its port
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module write_mux (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  lite_mux_pkg::aw_chan_t [`LM_NUM_PORTS-1:0]    port_aw_i,
  input  logic [`LM_NUM_PORTS-1:0]                      port_aw_valid_i,
  input  logic [`LM_NUM_PORTS-1:0]                      port_b_ready_i,
  input  lite_mux_pkg::w_chan_t [`LM_NUM_PORTS-1:0]     port_w_i,
  input  logic [`LM_NUM_PORTS-1:0]                      port_w_valid_i,
  output logic [`LM_NUM_PORTS-1:0]                      port_aw_ready_o,
  output logic [`LM_NUM_PORTS-1:0]                      port_w_ready_o,
  output logic [`LM_NUM_PORTS-1:0]                      port_b_valid_o,
  output lite_mux_pkg::b_chan_t                         port_b_o,
  output lite_mux_pkg::aw_chan_t                        mst_aw_o,
  output logic                                          mst_aw_valid_o,
  input  logic                                          mst_aw_ready_i,
  output lite_mux_pkg::w_chan_t                         mst_w_o,
  output logic                                          mst_w_valid_o,
  input  logic                                          mst_w_ready_i,
  input  lite_mux_pkg::b_chan_t                         mst_b_i,
  input  logic                                          mst_b_valid_i,
  output logic                                          mst_b_ready_o
);

  // Arbiter side handshake, gated by W FIFO space
  logic               aw_valid;
  logic               aw_ready;
  lite_mux_pkg::sel_t aw_sel;
  // Set once the index is pushed but AW is still stalled
  logic               lock_aw_q;
  logic               lock_aw_d;

  logic               w_push;
  logic               w_pop;
  logic               w_full;
  logic               w_empty;
  lite_mux_pkg::sel_t w_sel;

  logic               b_pop;
  logic               b_full;
  logic               b_empty;
  lite_mux_pkg::sel_t b_sel;

  // --------------------------------------------------------------------------
  // AW channel
  // --------------------------------------------------------------------------
  rr_arbiter #(
    .data_t (lite_mux_pkg::aw_chan_t)
  ) aw_arb_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (port_aw_valid_i),
    .data_i  (port_aw_i),
    .gnt_o   (port_aw_ready_o),
    .valid_o (aw_valid),
    .ready_i (aw_ready),
    .data_o  (mst_aw_o),
    .idx_o   (aw_sel)
  );

  always_comb begin
    lock_aw_d      = lock_aw_q;
    mst_aw_valid_o = 1'b0;
    aw_ready       = 1'b0;
    w_push         = 1'b0;
    if (lock_aw_q) begin
      // Already pushed, just finish the handshake
      mst_aw_valid_o = 1'b1;
      if (mst_aw_ready_i) begin
        aw_ready  = 1'b1;
        lock_aw_d = 1'b0;
      end
    end else if (aw_valid && !w_full) begin
      // New grant, record the order once
      mst_aw_valid_o = 1'b1;
      w_push         = 1'b1;
      if (mst_aw_ready_i) begin
        aw_ready = 1'b1;
      end else begin
        lock_aw_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_aw_q <= 1'b0;
    end else begin
      lock_aw_q <= lock_aw_d;
    end
  end

  route_fifo #(
    .depth (`LM_MAX_TRANS)
  ) w_fifo_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (w_push),
    .pop_i   (w_pop),
    .data_i  (aw_sel),
    .data_o  (w_sel),
    .full_o  (w_full),
    .empty_o (w_empty)
  );

  // --------------------------------------------------------------------------
  // W channel
  // --------------------------------------------------------------------------
  // Head port drives W, only with room for its B
  assign mst_w_o       = port_w_i[w_sel];
  assign mst_w_valid_o = ~w_empty & ~b_full & port_w_valid_i[w_sel];
  assign w_pop         = mst_w_valid_o & mst_w_ready_i;

  for (genvar i = 0; i < `LM_NUM_PORTS; i++) begin : gen_w_ready
    assign port_w_ready_o[i] = mst_w_ready_i & ~w_empty & ~b_full &
                               (w_sel == lite_mux_pkg::sel_t'(i));
  end

  // W transfer hands its index on to B
  route_fifo #(
    .depth (`LM_MAX_TRANS)
  ) b_fifo_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (w_pop),
    .pop_i   (b_pop),
    .data_i  (w_sel),
    .data_o  (b_sel),
    .full_o  (b_full),
    .empty_o (b_empty)
  );

  // --------------------------------------------------------------------------
  // B channel
  // --------------------------------------------------------------------------
  // Payload broadcast, valid to the owner only
  assign port_b_o      = mst_b_i;
  assign mst_b_ready_o = ~b_empty & port_b_ready_i[b_sel];
  assign b_pop         = mst_b_valid_i & mst_b_ready_o;

  for (genvar i = 0; i < `LM_NUM_PORTS; i++) begin : gen_b_valid
    assign port_b_valid_o[i] = mst_b_valid_i & ~b_empty &
                               (b_sel == lite_mux_pkg::sel_t'(i));
  end

endmodule

/* source/read_mux.sv */
// Read path: arbitrates AR and returns R to the issuing port in order
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module read_mux (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  lite_mux_pkg::ar_chan_t [`LM_NUM_PORTS-1:0]    port_ar_i,
  input  logic [`LM_NUM_PORTS-1:0]                      port_ar_valid_i,
  input  logic [`LM_NUM_PORTS-1:0]                      port_r_ready_i,
  output logic [`LM_NUM_PORTS-1:0]                      port_ar_ready_o,
  output logic [`LM_NUM_PORTS-1:0]                      port_r_valid_o,
  output lite_mux_pkg::r_chan_t                         port_r_o,
  output lite_mux_pkg::ar_chan_t                        mst_ar_o,
  output logic                                          mst_ar_valid_o,
  input  logic                                          mst_ar_ready_i,
  input  lite_mux_pkg::r_chan_t                         mst_r_i,
  input  logic                                          mst_r_valid_i,
  output logic                                          mst_r_ready_o
);

  logic               ar_valid;
  logic               ar_ready;
  lite_mux_pkg::sel_t ar_sel;

  logic               r_push;
  logic               r_pop;
  logic               r_full;
  logic               r_empty;
  lite_mux_pkg::sel_t r_sel;

  // --------------------------------------------------------------------------
  // AR channel
  // --------------------------------------------------------------------------
  rr_arbiter #(
    .data_t (lite_mux_pkg::ar_chan_t)
  ) ar_arb_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (port_ar_valid_i),
    .data_i  (port_ar_i),
    .gnt_o   (port_ar_ready_o),
    .valid_o (ar_valid),
    .ready_i (ar_ready),
    .data_o  (mst_ar_o),
    .idx_o   (ar_sel)
  );

  // No R before its AR, so push on the transfer itself
  assign mst_ar_valid_o = ~r_full & ar_valid;
  assign ar_ready       = ~r_full & mst_ar_ready_i;
  assign r_push         = mst_ar_valid_o & mst_ar_ready_i;

  route_fifo #(
    .depth (`LM_MAX_TRANS)
  ) r_fifo_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (r_push),
    .pop_i   (r_pop),
    .data_i  (ar_sel),
    .data_o  (r_sel),
    .full_o  (r_full),
    .empty_o (r_empty)
  );

  // --------------------------------------------------------------------------
  // R channel
  // --------------------------------------------------------------------------
  assign port_r_o      = mst_r_i;
  assign mst_r_ready_o = ~r_empty & port_r_ready_i[r_sel];
  assign r_pop         = mst_r_valid_i & mst_r_ready_o;

  for (genvar i = 0; i < `LM_NUM_PORTS; i++) begin : gen_r_valid
    assign port_r_valid_o[i] = mst_r_valid_i & ~r_empty &
                               (r_sel == lite_mux_pkg::sel_t'(i));
  end

endmodule

/* source/lite_mux.sv */
// AXI4-Lite round-robin multiplexer top, joins write and read paths to the bundles
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module lite_mux (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  lite_mux_pkg::lite_req_t [`LM_NUM_PORTS-1:0] port_req_i,
  output lite_mux_pkg::lite_resp_t [`LM_NUM_PORTS-1:0] port_resp_o,
  output lite_mux_pkg::lite_req_t                     mst_req_o,
  input  lite_mux_pkg::lite_resp_t                    mst_resp_i
);

  // Per-port fields pulled out of the request bundles
  lite_mux_pkg::aw_chan_t [`LM_NUM_PORTS-1:0] port_aw;
  lite_mux_pkg::w_chan_t [`LM_NUM_PORTS-1:0]  port_w;
  lite_mux_pkg::ar_chan_t [`LM_NUM_PORTS-1:0] port_ar;
  logic [`LM_NUM_PORTS-1:0] port_aw_valid, port_w_valid, port_b_ready;
  logic [`LM_NUM_PORTS-1:0] port_ar_valid, port_r_ready;
  // Results going back into the response bundles
  logic [`LM_NUM_PORTS-1:0] port_aw_ready, port_w_ready, port_b_valid;
  logic [`LM_NUM_PORTS-1:0] port_ar_ready, port_r_valid;
  lite_mux_pkg::b_chan_t port_b;
  lite_mux_pkg::r_chan_t port_r;

  for (genvar i = 0; i < `LM_NUM_PORTS; i++) begin : gen_port
    assign port_aw[i]       = port_req_i[i].aw;
    assign port_aw_valid[i] = port_req_i[i].aw_valid;
    assign port_w[i]        = port_req_i[i].w;
    assign port_w_valid[i]  = port_req_i[i].w_valid;
    assign port_b_ready[i]  = port_req_i[i].b_ready;
    assign port_ar[i]       = port_req_i[i].ar;
    assign port_ar_valid[i] = port_req_i[i].ar_valid;
    assign port_r_ready[i]  = port_req_i[i].r_ready;
    assign port_resp_o[i]   = '{aw_ready: port_aw_ready[i], w_ready: port_w_ready[i],
                                b: port_b, b_valid: port_b_valid[i],
                                ar_ready: port_ar_ready[i], r: port_r,
                                r_valid: port_r_valid[i]};
  end

  write_mux write_mux_inst (
    .clk_i (clk_i), .reset_i (reset_i),
    .port_aw_i (port_aw), .port_aw_valid_i (port_aw_valid),
    .port_b_ready_i (port_b_ready), .port_w_i (port_w),
    .port_w_valid_i (port_w_valid), .port_aw_ready_o (port_aw_ready),
    .port_w_ready_o (port_w_ready), .port_b_valid_o (port_b_valid),
    .port_b_o (port_b), .mst_aw_o (mst_req_o.aw),
    .mst_aw_valid_o (mst_req_o.aw_valid), .mst_aw_ready_i (mst_resp_i.aw_ready),
    .mst_w_o (mst_req_o.w), .mst_w_valid_o (mst_req_o.w_valid),
    .mst_w_ready_i (mst_resp_i.w_ready), .mst_b_i (mst_resp_i.b),
    .mst_b_valid_i (mst_resp_i.b_valid), .mst_b_ready_o (mst_req_o.b_ready)
  );

  read_mux read_mux_inst (
    .clk_i (clk_i), .reset_i (reset_i),
    .port_ar_i (port_ar), .port_ar_valid_i (port_ar_valid),
    .port_r_ready_i (port_r_ready), .port_ar_ready_o (port_ar_ready),
    .port_r_valid_o (port_r_valid), .port_r_o (port_r),
    .mst_ar_o (mst_req_o.ar), .mst_ar_valid_o (mst_req_o.ar_valid),
    .mst_ar_ready_i (mst_resp_i.ar_ready), .mst_r_i (mst_resp_i.r),
    .mst_r_valid_i (mst_resp_i.r_valid), .mst_r_ready_o (mst_req_o.r_ready)
  );

endmodule

/* dv/lite_mux_assert.sv */
// Concurrent checks on a routing FIFO handshake and on a held valid line
`timescale 1ns/1ps

module lite_mux_assert (
  input logic clk_i,
  input logic reset_i,
  input logic push_i,
  input logic pop_i,
  input logic full_i,
  input logic empty_i,
  input logic hold_valid_i,
  input logic hold_ready_i
);

  // No write into a full FIFO
  push_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
    !(push_i && full_i))
    else $error("routing FIFO pushed while full");

  // No read from an empty FIFO
  pop_not_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    !(pop_i && empty_i))
    else $error("routing FIFO popped while empty");

  // Valid stays up until accepted
  valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (hold_valid_i && !hold_ready_i) |=> hold_valid_i)
    else $error("valid dropped before it was accepted");

endmodule

/* dv/lite_mux_tb.sv */
// Trace-driven testbench for the AXI4-Lite multiplexer with a slave model
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module lite_mux_tb;

  localparam int unsigned trace_len  = 16;
  localparam int unsigned trace_cols = 6;
  localparam int unsigned clk_half   = 4;

  logic clk_i;
  logic reset_i;
  lite_mux_pkg::lite_req_t [`LM_NUM_PORTS-1:0]  port_req;
  lite_mux_pkg::lite_resp_t [`LM_NUM_PORTS-1:0] port_resp;
  lite_mux_pkg::lite_req_t  mst_req;
  lite_mux_pkg::lite_resp_t mst_resp;

  // Columns: port, kind, addr, wdata, resp, rdata
  logic [31:0] trace_mem [trace_len*trace_cols];
  int          err_cnt;
  int          chk_cnt;
  // Ports that wait for a B or an R
  logic [`LM_NUM_PORTS-1:0] wr_pend;
  logic [`LM_NUM_PORTS-1:0] rd_pend;
  // First master AW addresses
  logic [31:0] aw_order [$];
  int          aw_cnt;
  int          w_cnt;
  int          b_cnt;
  int          ar_cnt;
  int          r_cnt;

  initial clk_i = 1'b0;
  always #clk_half clk_i = ~clk_i;

  lite_mux lite_mux_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .port_req_i  (port_req),
    .port_resp_o (port_resp),
    .mst_req_o   (mst_req),
    .mst_resp_i  (mst_resp)
  );

  // Every routing FIFO, then the B FIFO with the master AW hold
  bind route_fifo lite_mux_assert fifo_chk_inst (
    .clk_i (clk_i), .reset_i (reset_i), .push_i (push_i), .pop_i (pop_i),
    .full_i (full_o), .empty_i (empty_o), .hold_valid_i (1'b0), .hold_ready_i (1'b0)
  );
  bind write_mux lite_mux_assert aw_chk_inst (
    .clk_i (clk_i), .reset_i (reset_i), .push_i (w_pop), .pop_i (b_pop),
    .full_i (b_full), .empty_i (b_empty), .hold_valid_i (mst_aw_valid_o),
    .hold_ready_i (mst_aw_ready_i)
  );

  function automatic logic [31:0] field(input int line, input int col);
    return trace_mem[line*trace_cols + col];
  endfunction

  // Trace line of a given kind and address, -1 if there is none
  function automatic int find_line(input logic [31:0] kind, input logic [31:0] addr);
    for (int n = 0; n < int'(trace_len); n++) begin
      if (field(n, 1) == kind && field(n, 2) == addr) begin
        return n;
      end
    end
    return -1;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_fault(input string what);
    err_cnt++;
    $display("[ERROR] %0t: %s", $time, what);
  endtask

  // --------------------------------------------------------------------------
  // Port side
  // --------------------------------------------------------------------------
  // Prot carries the port index, strobe is one-hot per port
  task automatic write_txn(input int p, input int n);
    logic aw_hs;
    logic w_hs;
    logic aw_done;
    logic w_done;
    logic b_seen;
    aw_done = 1'b0;
    w_done  = 1'b0;
    b_seen  = 1'b0;
    wr_pend[p] = 1'b1;
    // AW and W go up together
    port_req[p].aw.addr  = field(n, 2);
    port_req[p].aw.prot  = 3'(p);
    port_req[p].aw_valid = 1'b1;
    port_req[p].w.data   = field(n, 3);
    port_req[p].w.strb   = 4'(1 << p);
    port_req[p].w_valid  = 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      aw_hs = port_req[p].aw_valid && port_resp[p].aw_ready;
      w_hs  = port_req[p].w_valid && port_resp[p].w_ready;
      @(posedge clk_i);
      #1;
      if (aw_hs) begin
        port_req[p].aw_valid = 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        port_req[p].w_valid = 1'b0;
        w_done = 1'b1;
      end
    end
    while (!b_seen) begin
      @(negedge clk_i);
      if (port_resp[p].b_valid) begin
        b_seen = 1'b1;
        check_value($sformatf("port %0d B resp", p), 32'(port_resp[p].b.resp),
                    field(n, 4));
      end
      @(posedge clk_i);
      #1;
    end
    wr_pend[p] = 1'b0;
  endtask

  task automatic read_txn(input int p, input int n);
    logic ar_hs;
    logic r_seen;
    ar_hs  = 1'b0;
    r_seen = 1'b0;
    rd_pend[p] = 1'b1;
    port_req[p].ar.addr  = field(n, 2);
    port_req[p].ar.prot  = 3'(p);
    port_req[p].ar_valid = 1'b1;
    while (!ar_hs) begin
      @(negedge clk_i);
      ar_hs = port_req[p].ar_valid && port_resp[p].ar_ready;
      @(posedge clk_i);
      #1;
    end
    port_req[p].ar_valid = 1'b0;
    while (!r_seen) begin
      @(negedge clk_i);
      if (port_resp[p].r_valid) begin
        r_seen = 1'b1;
        check_value($sformatf("port %0d R data", p), port_resp[p].r.data, field(n, 5));
        check_value($sformatf("port %0d R resp", p), 32'(port_resp[p].r.resp),
                    field(n, 4));
      end
      @(posedge clk_i);
      #1;
    end
    rd_pend[p] = 1'b0;
  endtask

  // Trace lines of one port in order
  task automatic run_port(input int p);
    for (int n = 0; n < int'(trace_len); n++) begin
      if (field(n, 0) == 32'(p)) begin
        if (field(n, 1) == 32'd0) begin
          write_txn(p, n);
        end else begin
          read_txn(p, n);
        end
      end
    end
  endtask

  // Master AW and W must carry what the trace gives for that address and port
  task automatic match_write(input lite_mux_pkg::aw_chan_t aw,
                             input lite_mux_pkg::w_chan_t w);
    int n;
    n = find_line(32'd0, aw.addr);
    if (n < 0) begin
      report_fault($sformatf("master write to address %h that no port issued", aw.addr));
    end else begin
      check_value($sformatf("master AW prot for %h", aw.addr), 32'(aw.prot), field(n, 0));
      check_value($sformatf("master W data for %h", aw.addr), w.data, field(n, 3));
      check_value($sformatf("master W strb for %h", aw.addr), 32'(w.strb),
                  32'(1) << field(n, 0));
    end
  endtask

  // Master AR must come from a trace read of the port named in prot
  task automatic verify_read(input lite_mux_pkg::ar_chan_t ar);
    int n;
    n = find_line(32'd1, ar.addr);
    if (n < 0) begin
      report_fault($sformatf("master read of address %h that no port issued", ar.addr));
    end else begin
      check_value($sformatf("master AR prot for %h", ar.addr), 32'(ar.prot), field(n, 0));
    end
  endtask

  // --------------------------------------------------------------------------
  // Slave model on the master port
  // --------------------------------------------------------------------------
  initial begin : slave_model
    logic [31:0]            rnd;
    lite_mux_pkg::aw_chan_t aw;
    lite_mux_pkg::w_chan_t  w;
    lite_mux_pkg::ar_chan_t ar;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   b_hs;
    logic                   ar_hs;
    logic                   r_hs;
    lite_mux_pkg::aw_chan_t aw_q [$];
    lite_mux_pkg::w_chan_t  w_q [$];
    lite_mux_pkg::ar_chan_t ar_q [$];
    logic [`LM_RESP_W-1:0] b_q [$];
    lite_mux_pkg::r_chan_t r_q [$];
    rnd      = 32'd72327;
    mst_resp = '0;
    forever begin
      @(negedge clk_i);
      b_hs = 1'b0;
      r_hs = 1'b0;
      if (!reset_i) begin
        aw_hs = mst_req.aw_valid && mst_resp.aw_ready;
        w_hs  = mst_req.w_valid && mst_resp.w_ready;
        b_hs  = mst_resp.b_valid && mst_req.b_ready;
        ar_hs = mst_req.ar_valid && mst_resp.ar_ready;
        r_hs  = mst_resp.r_valid && mst_req.r_ready;
        if (aw_hs) begin
          aw_q.push_back(mst_req.aw);
          if (aw_order.size() < `LM_NUM_PORTS) begin
            aw_order.push_back(mst_req.aw.addr);
          end
          aw_cnt++;
        end
        if (w_hs) begin
          w_q.push_back(mst_req.w);
          w_cnt++;
        end
        if (b_hs) b_cnt++;
        if (ar_hs) begin
          ar_q.push_back(mst_req.ar);
          ar_cnt++;
        end
        if (r_hs) r_cnt++;
        // Pair AW with W, bit 31 selects the error response
        while (aw_q.size() > 0 && w_q.size() > 0) begin
          aw = aw_q.pop_front();
          w  = w_q.pop_front();
          match_write(aw, w);
          b_q.push_back(aw.addr[31] ? `LM_RESP_SLVERR : `LM_RESP_OKAY);
        end
        while (ar_q.size() > 0) begin
          ar = ar_q.pop_front();
          verify_read(ar);
          r_q.push_back('{data: ~ar.addr,
                          resp: (ar.addr[31] ? `LM_RESP_SLVERR : `LM_RESP_OKAY)});
        end
        if (aw_cnt - b_cnt > `LM_MAX_TRANS) begin
          report_fault("more writes in flight than the routing depth allows");
        end
        if (ar_cnt - r_cnt > `LM_MAX_TRANS) begin
          report_fault("more reads in flight than the routing depth allows");
        end
        // Responses only reach a port that waits for one
        for (int p = 0; p < `LM_NUM_PORTS; p++) begin
          if (port_resp[p].b_valid && !wr_pend[p]) begin
            report_fault($sformatf("B delivered to port %0d with no write open", p));
          end
          if (port_resp[p].r_valid && !rd_pend[p]) begin
            report_fault($sformatf("R delivered to port %0d with no read open", p));
          end
        end
      end
      @(posedge clk_i);
      #1;
      if (b_hs) mst_resp.b_valid = 1'b0;
      if (r_hs) mst_resp.r_valid = 1'b0;
      // Random stalls, ready three times in four
      rnd = xorshift(rnd);
      mst_resp.aw_ready = rnd[0] | rnd[1];
      mst_resp.w_ready  = rnd[2] | rnd[3];
      mst_resp.ar_ready = rnd[4] | rnd[5];
      if (!mst_resp.b_valid && b_q.size() > 0 && rnd[6]) begin
        mst_resp.b_valid = 1'b1;
        mst_resp.b.resp  = b_q.pop_front();
      end
      if (!mst_resp.r_valid && r_q.size() > 0 && rnd[7]) begin
        mst_resp.r_valid = 1'b1;
        mst_resp.r       = r_q.pop_front();
      end
    end
  end

  // --------------------------------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin : watchdog
    repeat (trace_len * 200) @(posedge clk_i);
    $display("Run stopped by the watchdog before all transactions completed");
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main_seq
    int n_wr;
    int n_rd;
    port_req = '0;
    reset_i  = 1'b1;
    err_cnt  = 0;
    chk_cnt  = 0;
    wr_pend  = '0;
    rd_pend  = '0;
    aw_cnt   = 0;
    w_cnt    = 0;
    b_cnt    = 0;
    ar_cnt   = 0;
    r_cnt    = 0;
    $readmemh("dv/lite_mux_trace.txt", trace_mem);
    // Writes and reads the trace asks for
    n_wr = 0;
    n_rd = 0;
    for (int n = 0; n < int'(trace_len); n++) begin
      if (field(n, 1) == 32'd0) begin
        n_wr++;
      end else begin
        n_rd++;
      end
    end
    for (int p = 0; p < `LM_NUM_PORTS; p++) begin
      port_req[p].b_ready = 1'b1;
      port_req[p].r_ready = 1'b1;
    end
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    // Idle state straight after reset
    @(negedge clk_i);
    check_value("master w_valid after reset", 32'(mst_req.w_valid), 32'd0);
    for (int p = 0; p < `LM_NUM_PORTS; p++) begin
      check_value($sformatf("port %0d b_valid after reset", p),
                  32'(port_resp[p].b_valid), 32'd0);
      check_value($sformatf("port %0d r_valid after reset", p),
                  32'(port_resp[p].r_valid), 32'd0);
    end
    @(posedge clk_i);
    #1;
    check_value("transfers before stimulus", 32'(aw_cnt + w_cnt + ar_cnt), 32'd0);
    fork
      run_port(0);
      run_port(1);
      run_port(2);
      run_port(3);
    join
    repeat (4) @(posedge clk_i);
    // Opening writes of all ports, granted in port order
    if (aw_order.size() < `LM_NUM_PORTS) begin
      report_fault("fewer master AW transfers than ports");
    end else begin
      for (int k = 0; k < `LM_NUM_PORTS; k++) begin
        check_value($sformatf("master AW number %0d", k), aw_order[k], field(k, 2));
      end
    end
    // One address, one data beat and one response per trace line
    check_value("master AW count", 32'(aw_cnt), 32'(n_wr));
    check_value("master W count", 32'(w_cnt), 32'(n_wr));
    check_value("master B count", 32'(b_cnt), 32'(n_wr));
    check_value("master AR count", 32'(ar_cnt), 32'(n_rd));
    check_value("master R count", 32'(r_cnt), 32'(n_rd));
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* dv/lite_mux_trace.txt */
// port kind(0 write, 1 read) addr wdata resp rdata
// resp 0 is OKAY, 2 is SLVERR; rdata is the inverted address
0 0 00001000 11110000 0 00000000
1 0 00002004 22220001 0 00000000
2 0 80003008 33330002 2 00000000
3 0 0000400c 44440003 0 00000000
0 1 00001000 00000000 0 ffffefff
1 1 80002004 00000000 2 7fffdffb
2 0 00003010 55550004 0 00000000
3 1 0000400c 00000000 0 ffffbff3
0 0 80001014 66660005 2 00000000
1 0 00002018 77770006 0 00000000
2 1 00003010 00000000 0 ffffcfef
3 0 8000401c 88880007 2 00000000
0 1 00001014 00000000 0 ffffefeb
1 1 00002018 00000000 0 ffffdfe7
2 1 80003008 00000000 2 7fffcff7
3 1 0000401c 00000000 0 ffffbfe3

/* vlog.f */
+incdir+source
source/lite_mux_pkg.sv
source/rr_arbiter.sv
source/route_fifo.sv
source/write_mux.sv
source/read_mux.sv
source/lite_mux.sv
dv/lite_mux_assert.sv
dv/lite_mux_tb.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= lite_mux_tb
FILELIST ?= vlog.f
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
